// File: Bender.yml
package:
  name: xfcp_id_endpoint

sources:
  - common/xfcp_pkg.sv
  - design/xfcp_id_rom.sv
  - design/xfcp_skid_buffer.sv
  - xfcp_endpoint/xfcp_frame_parser.sv
  - xfcp_endpoint/xfcp_id_endpoint.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_xfcp_id_endpoint.sv

// File: common/xfcp_pkg.sv
package xfcp_pkg;

    // one byte of the XFCP stream
    typedef logic [7:0] xfcp_byte_t;

    // framing bytes
    localparam xfcp_byte_t start_tag = 8'hFF;
    localparam xfcp_byte_t rpath_tag = 8'hFE;

    // request and response types
    localparam xfcp_byte_t id_req  = 8'hFE;
    localparam xfcp_byte_t id_resp = 8'hFF;

    // single byte sent after the start tag on an unknown request
    localparam xfcp_byte_t err_byte = 8'h00;

    // ID table, 16 binary bytes then 16 string bytes
    localparam int id_rom_depth = 32;

    typedef logic [4:0] id_ptr_t;

    // up to 16 characters, right aligned as a string literal lands
    typedef logic [127:0] id_str_t;

endpackage

// File: design/xfcp_id_rom.sv
module xfcp_id_rom import xfcp_pkg::*; #(
    parameter logic [15:0] id_type = 16'h2C00,
    parameter id_str_t     id_str  = "XFCP Ident"
) (
    input  id_ptr_t    rom_addr_i,
    output xfcp_byte_t rom_data_o
);

    typedef xfcp_byte_t [id_rom_depth-1:0] rom_t;

    function automatic rom_t build_rom(input logic [15:0] t, input id_str_t s);
        rom_t rom;
        int   len;
        rom = '0;
        len = 0;

        // module type, low byte first
        rom[0] = t[7:0];
        rom[1] = t[15:8];

        // length up to the highest non-zero character
        for (int i = 0; i < 16; i++) begin
            if (s[8*i +: 8] != 8'h00) begin
                len = i + 1;
            end
        end

        // first character sits in the highest used byte of the literal
        for (int i = 0; i < 16; i++) begin
            if (i < len) begin
                rom[16 + i] = s[8*(len - 1 - i) +: 8];
            end
        end

        return rom;
    endfunction

    localparam rom_t rom_table = build_rom(id_type, id_str);

    assign rom_data_o = rom_table[rom_addr_i];

endmodule

// File: design/xfcp_skid_buffer.sv
module xfcp_skid_buffer import xfcp_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  xfcp_byte_t int_data_i,
    input  logic       int_valid_i,
    input  logic       int_last_i,
    input  logic       int_user_i,
    output logic       int_ready_early_o,
    output logic       int_ready_o,

    output xfcp_byte_t out_data_o,
    output logic       out_valid_o,
    input  logic       out_ready_i,
    output logic       out_last_o,
    output logic       out_user_o
);

    xfcp_byte_t out_data_q;
    logic       out_valid_q;
    logic       out_valid_d;
    logic       out_last_q;
    logic       out_user_q;

    xfcp_byte_t tmp_data_q;
    logic       tmp_valid_q;
    logic       tmp_valid_d;
    logic       tmp_last_q;
    logic       tmp_user_q;

    logic       ready_q;
    logic       int_to_out;
    logic       int_to_tmp;
    logic       tmp_to_out;

    assign out_data_o  = out_data_q;
    assign out_valid_o = out_valid_q;
    assign out_last_o  = out_last_q;
    assign out_user_o  = out_user_q;
    assign int_ready_o = ready_q;

    // room next cycle unless temp would fill up behind a stalled output
    assign int_ready_early_o = out_ready_i | (!tmp_valid_q & (!out_valid_q | !int_valid_i));

    always_comb begin
        out_valid_d = out_valid_q;
        tmp_valid_d = tmp_valid_q;
        int_to_out  = 1'b0;
        int_to_tmp  = 1'b0;
        tmp_to_out  = 1'b0;

        if (ready_q) begin
            if (out_ready_i || !out_valid_q) begin
                out_valid_d = int_valid_i;
                int_to_out  = 1'b1;
            end else begin
                // output stalled, park the byte
                tmp_valid_d = int_valid_i;
                int_to_tmp  = 1'b1;
            end
        end else if (out_ready_i) begin
            out_valid_d = tmp_valid_q;
            tmp_valid_d = 1'b0;
            tmp_to_out  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
            tmp_valid_q <= 1'b0;
            ready_q     <= 1'b0;
        end else begin
            out_valid_q <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
            ready_q     <= int_ready_early_o;
        end

        if (int_to_out) begin
            out_data_q <= int_data_i;
            out_last_q <= int_last_i;
            out_user_q <= int_user_i;
        end else if (tmp_to_out) begin
            out_data_q <= tmp_data_q;
            out_last_q <= tmp_last_q;
            out_user_q <= tmp_user_q;
        end

        if (int_to_tmp) begin
            tmp_data_q <= int_data_i;
            tmp_last_q <= int_last_i;
            tmp_user_q <= int_user_i;
        end
    end

    // a stalled beat holds until the sink takes it
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
            && $stable(out_last_o) && $stable(out_user_o));

endmodule

// File: tests/xfcp_ref_model.svh
`ifndef xfcp_ref_model_svh
`define xfcp_ref_model_svh

// expected ID table, binary part then the name text first character first
function automatic xfcp_byte_t id_byte(input int idx);
    if (idx == 0) begin
        return dut_id_type[7:0];
    end else if (idx == 1) begin
        return dut_id_type[15:8];
    end else if (idx >= 16 && idx - 16 < id_text.len()) begin
        return id_text[idx - 16];
    end
    return 8'h00;
endfunction

task automatic expect_beat(input xfcp_byte_t data, input bit last, input bit user, input int p);
    exp_data.push_back(data);
    exp_last.push_back(last);
    exp_user.push_back(user);
    exp_pkt.push_back(p);
endtask

// reply for packet p, appended in output order
task automatic model_packet(input int p);
    int hdr;
    int n;
    hdr = -1;
    n = pkt_len[p];
    // lone bytes and untagged packets get no reply
    if (n < 2 || (pkt_data[p][0] != start_tag && pkt_data[p][0] != rpath_tag)) begin
        return;
    end
    for (int i = 0; i < n; i++) begin
        if (hdr < 0 && pkt_data[p][i] == start_tag) begin
            hdr = i;
        end
    end
    // no type byte, so the whole packet is header and its tail is flagged
    if (hdr < 0 || hdr == n - 1) begin
        for (int i = 0; i < n; i++) begin
            expect_beat(pkt_data[p][i], i == n - 1, i == n - 1, p);
        end
        return;
    end
    for (int i = 0; i <= hdr; i++) begin
        expect_beat(pkt_data[p][i], 1'b0, 1'b0, p);
    end
    if (pkt_data[p][hdr + 1] == id_req) begin
        expect_beat(id_resp, 1'b0, 1'b0, p);
        for (int i = 0; i < id_rom_depth; i++) begin
            expect_beat(id_byte(i), i == id_rom_depth - 1, 1'b0, p);
        end
    end else begin
        expect_beat(err_byte, 1'b1, 1'b1, p);
    end
endtask

`endif

// File: tests/tb_xfcp_id_endpoint.sv
module tb_xfcp_id_endpoint import xfcp_pkg::*; ();

    localparam int          num_pkts    = 40;
    localparam int          max_len     = 12;
    localparam logic [15:0] dut_id_type = 16'h2C00;
    localparam id_str_t     dut_id_str  = "XFCP Ident";

    logic       clk;
    logic       rst;
    xfcp_byte_t in_data_i;
    logic       in_valid_i;
    logic       in_last_i;
    logic       in_ready_o;
    xfcp_byte_t out_data_o;
    logic       out_valid_o;
    logic       out_ready_i;
    logic       out_last_o;
    logic       out_user_o;

    // stimulus packets and the expected reply beats
    xfcp_byte_t pkt_data[num_pkts][max_len];
    int         pkt_len[num_pkts];
    string      id_text = "XFCP Ident";
    xfcp_byte_t exp_data[$];
    bit         exp_last[$];
    bit         exp_user[$];
    int         exp_pkt[$];

    int         pkt_no;
    int         byte_idx;
    bit         offer_fire;
    bit         stalled;
    xfcp_byte_t held_data;
    logic       held_last;
    logic       held_user;
    int         mismatches;
    int         failures;
    int         cycles;
    int         limit;
    int         in_total;

    `include "xfcp_ref_model.svh"

    xfcp_id_endpoint #(
        .id_type (dut_id_type),
        .id_str  (dut_id_str)
    ) xfcp_id_endpoint_inst (
        .clk         (clk),
        .rst         (rst),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .in_last_i   (in_last_i),
        .in_ready_o  (in_ready_o),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_last_o  (out_last_o),
        .out_user_o  (out_user_o)
    );

    always #50 clk = ~clk;

    task automatic check_byte(input string name, input xfcp_byte_t exp, input xfcp_byte_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
        end
    endtask

    // packet kinds are identify, routed identify, bad type, bad start and single byte
    task automatic make_packet(input int p);
        int kind;
        int route;
        kind = $urandom_range(4);
        for (int i = 0; i < max_len; i++) begin
            pkt_data[p][i] = xfcp_byte_t'($urandom_range(255));
        end
        pkt_len[p] = $urandom_range(max_len, 2);
        case (kind)
            0: begin
                pkt_data[p][0] = start_tag;
                pkt_data[p][1] = id_req;
            end
            1: begin
                route = $urandom_range(3);
                pkt_data[p][0] = rpath_tag;
                // hop bytes stay below the start tag
                for (int i = 1; i <= route; i++) begin
                    pkt_data[p][i] = xfcp_byte_t'($urandom_range(254));
                end
                pkt_data[p][route + 1] = start_tag;
                pkt_data[p][route + 2] = id_req;
            end
            2: begin
                pkt_data[p][0] = start_tag;
                if (pkt_data[p][1] == id_req || $urandom_range(1) == 1) begin
                    pkt_data[p][1] = 8'h2C;
                end
            end
            3: begin
                pkt_data[p][0] = xfcp_byte_t'($urandom_range(253));
            end
            default: begin
                pkt_len[p] = 1;
            end
        endcase
    endtask

    // runs on the falling edge so an offered beat moves on the next rising edge
    task automatic drive_input();
        if (offer_fire) begin
            byte_idx++;
            if (byte_idx == pkt_len[pkt_no]) begin
                pkt_no++;
                byte_idx = 0;
            end
        end
        if (pkt_no < num_pkts) begin
            if (!in_valid_i || offer_fire) begin
                in_valid_i = ($urandom_range(99) < 80);
            end
            in_data_i = pkt_data[pkt_no][byte_idx];
            in_last_i = (byte_idx == pkt_len[pkt_no] - 1);
        end else begin
            in_valid_i = 1'b0;
            in_last_i  = 1'b0;
        end
        offer_fire = in_valid_i && in_ready_o;
    endtask

    task automatic collect_output();
        string name;
        if (stalled) begin
            check_flag("stall hold valid", 1'b1, out_valid_o);
            check_byte("stall hold data", held_data, out_data_o);
            check_flag("stall hold last", held_last, out_last_o);
            check_flag("stall hold user", held_user, out_user_o);
        end
        out_ready_i = ($urandom_range(99) < 70);
        if (out_valid_o && out_ready_i) begin
            if (exp_data.size() == 0) begin
                failures++;
                $display("output byte %h arrived while no reply was pending", out_data_o);
            end else begin
                name = $sformatf("packet %0d", exp_pkt.pop_front());
                check_byte({name, " data"}, exp_data.pop_front(), out_data_o);
                check_flag({name, " last"}, exp_last.pop_front(), out_last_o);
                check_flag({name, " user"}, exp_user.pop_front(), out_user_o);
            end
        end
        stalled   = out_valid_o && !out_ready_i;
        held_data = out_data_o;
        held_last = out_last_o;
        held_user = out_user_o;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        in_last_i   = 1'b0;
        out_ready_i = 1'b0;
        pkt_no      = 0;
        byte_idx    = 0;
        offer_fire  = 1'b0;
        stalled     = 1'b0;
        mismatches  = 0;
        failures    = 0;
        cycles      = 0;
        in_total    = 0;
        void'($urandom(53));

        for (int p = 0; p < num_pkts; p++) begin
            make_packet(p);
            model_packet(p);
            in_total += pkt_len[p];
        end
        limit = 4 * (in_total + exp_data.size()) + 200;

        repeat (5) begin
            @(negedge clk);
            check_flag("reset in_ready", 1'b0, in_ready_o);
            check_flag("reset out_valid", 1'b0, out_valid_o);
        end
        rst = 1'b0;
        // first cycle out of reset before any edge has sampled rst low
        #25;
        check_flag("post reset in_ready", 1'b0, in_ready_o);
        check_flag("post reset out_valid", 1'b0, out_valid_o);

        while ((pkt_no < num_pkts || exp_data.size() > 0) && cycles < limit) begin
            @(negedge clk);
            cycles++;
            drive_input();
            collect_output();
        end

        if (pkt_no < num_pkts || exp_data.size() > 0) begin
            failures++;
            $display("timeout after %0d cycles, %0d packets unsent and %0d reply bytes missing",
                     cycles, num_pkts - pkt_no, exp_data.size());
        end else begin
            // nothing more may come out
            repeat (20) begin
                @(negedge clk);
                drive_input();
                collect_output();
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tests
common/xfcp_pkg.sv
design/xfcp_id_rom.sv
design/xfcp_skid_buffer.sv
xfcp_endpoint/xfcp_frame_parser.sv
xfcp_endpoint/xfcp_id_endpoint.sv
tests/tb_xfcp_id_endpoint.sv

// File: xfcp_endpoint/xfcp_frame_parser.sv
module xfcp_frame_parser import xfcp_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  xfcp_byte_t in_data_i,
    input  logic       in_valid_i,
    input  logic       in_last_i,
    output logic       in_ready_o,

    output xfcp_byte_t int_data_o,
    output logic       int_valid_o,
    output logic       int_last_o,
    output logic       int_user_o,
    input  logic       int_ready_early_i,
    input  logic       int_ready_i,

    output id_ptr_t    rom_addr_o,
    input  xfcp_byte_t rom_data_i
);

    typedef enum logic [2:0] {
        st_idle,
        st_route,
        st_type,
        st_identify,
        st_discard
    } state_t;

    state_t  state_q;
    state_t  state_d;
    logic    in_ready_q;
    logic    in_ready_d;
    id_ptr_t id_ptr_q;
    id_ptr_t id_ptr_d;
    logic    last_seen_q;

    logic    in_fire;
    logic    pkt_done;
    logic    id_end;

    assign in_ready_o = in_ready_q;
    assign rom_addr_o = id_ptr_q;
    assign in_fire    = in_ready_q & in_valid_i;

    // input packet fully consumed including this cycle
    assign pkt_done = last_seen_q | (in_fire & in_last_i);
    assign id_end   = (id_ptr_q == id_ptr_t'(id_rom_depth - 1));

    always_comb begin
        state_d     = state_q;
        in_ready_d  = int_ready_early_i;
        id_ptr_d    = id_ptr_q;
        int_data_o  = in_data_i;
        int_valid_o = 1'b0;
        int_last_o  = 1'b0;
        int_user_o  = 1'b0;

        case (state_q)
            st_idle: begin
                id_ptr_d = '0;
                // a lone byte with last set is dropped silently
                if (in_fire && !in_last_i) begin
                    if (in_data_i == rpath_tag) begin
                        int_valid_o = 1'b1;
                        state_d     = st_route;
                    end else if (in_data_i == start_tag) begin
                        int_valid_o = 1'b1;
                        state_d     = st_type;
                    end else begin
                        in_ready_d = 1'b1;
                        state_d    = st_discard;
                    end
                end
            end
            st_route: begin
                if (in_fire) begin
                    int_valid_o = 1'b1;
                    if (in_last_i) begin
                        // truncated route path
                        int_last_o = 1'b1;
                        int_user_o = 1'b1;
                        state_d    = st_idle;
                    end else if (in_data_i == start_tag) begin
                        state_d = st_type;
                    end
                end
            end
            st_type: begin
                if (in_fire) begin
                    int_valid_o = 1'b1;
                    if (in_data_i == id_req) begin
                        int_data_o = id_resp;
                        // drain padding while the ID goes out
                        in_ready_d = !in_last_i;
                        state_d    = st_identify;
                    end else begin
                        int_data_o = err_byte;
                        int_last_o = 1'b1;
                        int_user_o = 1'b1;
                        if (in_last_i) begin
                            state_d = st_idle;
                        end else begin
                            in_ready_d = 1'b1;
                            state_d    = st_discard;
                        end
                    end
                end
            end
            st_identify: begin
                in_ready_d  = !pkt_done;
                int_data_o  = rom_data_i;
                int_valid_o = int_ready_i;
                if (int_ready_i) begin
                    id_ptr_d = id_ptr_t'(id_ptr_q + 1'b1);
                    if (id_end) begin
                        int_last_o = 1'b1;
                        if (pkt_done) begin
                            in_ready_d = int_ready_early_i;
                            state_d    = st_idle;
                        end else begin
                            state_d = st_discard;
                        end
                    end
                end
            end
            st_discard: begin
                in_ready_d = 1'b1;
                if (in_fire && in_last_i) begin
                    in_ready_d = int_ready_early_i;
                    state_d    = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= st_idle;
            in_ready_q  <= 1'b0;
            id_ptr_q    <= '0;
            last_seen_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            in_ready_q <= in_ready_d;
            id_ptr_q   <= id_ptr_d;
            if (in_fire) begin
                last_seen_q <= in_last_i;
            end
        end
    end

    // every table read starts at entry zero and ends back there
    rom_from_start: assert property (@(posedge clk) disable iff (rst)
        state_q != st_identify |-> rom_addr_o == '0);

    // bytes only go out while the skid buffer has sampled room
    valid_needs_ready: assert property (@(posedge clk) disable iff (rst)
        int_valid_o |-> int_ready_i);

endmodule

// File: xfcp_endpoint/xfcp_id_endpoint.sv
module xfcp_id_endpoint import xfcp_pkg::*; #(
    parameter logic [15:0] id_type = 16'h2C00,
    parameter id_str_t     id_str  = "XFCP Ident"
) (
    input  logic       clk,
    input  logic       rst,

    input  xfcp_byte_t in_data_i,
    input  logic       in_valid_i,
    input  logic       in_last_i,
    output logic       in_ready_o,

    output xfcp_byte_t out_data_o,
    output logic       out_valid_o,
    input  logic       out_ready_i,
    output logic       out_last_o,
    output logic       out_user_o
);

    xfcp_byte_t int_data;
    logic       int_valid;
    logic       int_last;
    logic       int_user;
    logic       int_ready_early;
    logic       int_ready;
    id_ptr_t    rom_addr;
    xfcp_byte_t rom_data;

    xfcp_frame_parser parser_inst (
        .clk               (clk),
        .rst               (rst),
        .in_data_i         (in_data_i),
        .in_valid_i        (in_valid_i),
        .in_last_i         (in_last_i),
        .in_ready_o        (in_ready_o),
        .int_data_o        (int_data),
        .int_valid_o       (int_valid),
        .int_last_o        (int_last),
        .int_user_o        (int_user),
        .int_ready_early_i (int_ready_early),
        .int_ready_i       (int_ready),
        .rom_addr_o        (rom_addr),
        .rom_data_i        (rom_data)
    );

    xfcp_id_rom #(
        .id_type (id_type),
        .id_str  (id_str)
    ) rom_inst (
        .rom_addr_i (rom_addr),
        .rom_data_o (rom_data)
    );

    xfcp_skid_buffer skid_inst (
        .clk               (clk),
        .rst               (rst),
        .int_data_i        (int_data),
        .int_valid_i       (int_valid),
        .int_last_i        (int_last),
        .int_user_i        (int_user),
        .int_ready_early_o (int_ready_early),
        .int_ready_o       (int_ready),
        .out_data_o        (out_data_o),
        .out_valid_o       (out_valid_o),
        .out_ready_i       (out_ready_i),
        .out_last_o        (out_last_o),
        .out_user_o        (out_user_o)
    );

endmodule
